//--- wb_bus_config.svh
`ifndef WB_BUS_CONFIG_SVH
`define WB_BUS_CONFIG_SVH

// bus geometry
`define WB_AW 32
`define WB_DW 32
`define WB_SW 4

// four windows, each one selected by the top address nibble
`define WB_NS 4
`define WB_BASE0 32'h0000_0000
`define WB_BASE1 32'h1000_0000
`define WB_BASE2 32'h2000_0000
`define WB_BASE3 32'h3000_0000
`define WB_MASK 32'hF000_0000

// window 3 decodes but is refused
`define WB_ACCESS_ALLOWED 4'b0111

// slave sizing
`define WB_RAM_WORDS 256
`define WB_ID_VALUE 32'h5742_0001
`define WB_REG_COUNT 4
`endif

//--- wb_bus_pkg.sv
`include "wb_bus_config.svh"

package wb_bus_pkg;

	// bus payload types
	typedef logic [`WB_AW-1:0] addr_t;
	typedef logic [`WB_DW-1:0] data_t;
	typedef logic [`WB_SW-1:0] sel_t;

	// one bit per window, none-selected flag on top
	typedef logic [`WB_NS:0] decode_t;

	// slave index, values line up with the decode bit positions
	typedef enum logic [2:0] {SLV_RAM0, SLV_REGS, SLV_RAM1, SLV_RSVD, SLV_NONE} slave_e;

	// splitter FSM
	typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_ERR} split_state_e;

	// register block word offsets
	typedef enum logic [1:0] {REG_ID, REG_SCRATCH0, REG_SCRATCH1, REG_COUNT} reg_addr_e;

endpackage

//--- wb_if.sv
`timescale 1ns/1ps

interface wb_if;

	// request side, driven by the master
	logic               cyc;
	logic               stb;
	logic               we;
	wb_bus_pkg::addr_t  adr;
	wb_bus_pkg::data_t  dat_w;
	wb_bus_pkg::sel_t   sel;

	// response side, driven by the slave
	// ack and err are single-cycle pulses and never high together
	logic               ack;
	logic               err;
	wb_bus_pkg::data_t  dat_r;

	modport master
	(
		output cyc, stb, we, adr, dat_w, sel,
		input  ack, err, dat_r
	);

	modport slave
	(
		input  cyc, stb, we, adr, dat_w, sel,
		output ack, err, dat_r
	);

endinterface

//--- addr_decode.sv
`timescale 1ns/1ps
`include "wb_bus_config.svh"

module addr_decode
(
	input  logic                 i_valid,
	input  wb_bus_pkg::addr_t    i_addr,
	output wb_bus_pkg::decode_t  o_decode
);

	////////////////////////////////////////////////////////////////////////////
	// window table
	////////////////////////////////////////////////////////////////////////////

	// bases packed with window 0 in the low word
	localparam logic [`WB_NS*`WB_AW-1:0] SLAVE_BASE =
		{`WB_BASE3, `WB_BASE2, `WB_BASE1, `WB_BASE0};

	// every window uses the same compare mask
	localparam wb_bus_pkg::addr_t SLAVE_MASK = `WB_MASK;

	// a window may match in the compare and still be refused here
	localparam logic [`WB_NS-1:0] ALLOWED = `WB_ACCESS_ALLOWED;

	// per-window match before valid qualification
	logic [`WB_NS-1:0] prematch;

	////////////////////////////////////////////////////////////////////////////
	// masked compare
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int i = 0; i < `WB_NS; i++)
		begin
			// xor leaves ones only where address and base differ
			prematch[i] = (((i_addr ^ SLAVE_BASE[i*`WB_AW +: `WB_AW]) & SLAVE_MASK) == '0)
				&& ALLOWED[i];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// one-hot output
	////////////////////////////////////////////////////////////////////////////

	// bases are distinct under the mask, so at most one prematch bit is set
	always_comb
	begin
		o_decode = '0;
		if (i_valid)
		begin
			o_decode[`WB_NS-1:0] = prematch;
			// no allowed window claims the address, the splitter answers with err
			o_decode[`WB_NS] = (prematch == '0);
		end
	end

endmodule

//--- wb_splitter.sv
`timescale 1ns/1ps

module wb_splitter
(
	input  logic  i_clk,
	input  logic  i_reset,
	wb_if.slave   m,
	wb_if.master  s_ram0,
	wb_if.master  s_regs,
	wb_if.master  s_ram1
);

	// position of the none-selected flag in the decode word
	localparam int NONE_BIT = $bits(wb_bus_pkg::decode_t) - 1;

	wb_bus_pkg::split_state_e  state;
	wb_bus_pkg::split_state_e  next_state;
	wb_bus_pkg::decode_t       decode;
	wb_bus_pkg::slave_e        dec_slave;
	wb_bus_pkg::slave_e        r_slave;
	wb_bus_pkg::slave_e        target;
	logic                      dec_valid;
	logic                      dec_err;
	logic                      sel_ack;
	logic                      sel_err;
	wb_bus_pkg::data_t         sel_dat;

	// only a fresh strobe in idle gets decoded
	assign dec_valid = m.cyc && m.stb && (state == wb_bus_pkg::ST_IDLE);

	addr_decode u_addr_decode
	(
		.i_valid  (dec_valid),
		.i_addr   (m.adr),
		.o_decode (decode)
	);

	// one-hot to slave index
	always_comb
	begin
		dec_slave = wb_bus_pkg::SLV_NONE;
		if (decode[int'(wb_bus_pkg::SLV_RAM0)])
			dec_slave = wb_bus_pkg::SLV_RAM0;
		else if (decode[int'(wb_bus_pkg::SLV_REGS)])
			dec_slave = wb_bus_pkg::SLV_REGS;
		else if (decode[int'(wb_bus_pkg::SLV_RAM1)])
			dec_slave = wb_bus_pkg::SLV_RAM1;
	end

	// refused window 3 and unmapped addresses both land on the none flag
	assign dec_err = decode[NONE_BIT];

	////////////////////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		next_state = state;
		case (state)
			wb_bus_pkg::ST_IDLE:
				if (dec_err)
					next_state = wb_bus_pkg::ST_ERR;
				else if (dec_valid)
					next_state = wb_bus_pkg::ST_WAIT;
			// master abort or slave response both end the transfer
			wb_bus_pkg::ST_WAIT:
				if (!m.cyc || m.ack || m.err)
					next_state = wb_bus_pkg::ST_IDLE;
			default:
				next_state = wb_bus_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state <= wb_bus_pkg::ST_IDLE;
			r_slave <= wb_bus_pkg::SLV_NONE;
		end
		else
		begin
			state <= next_state;
			// latch the target as the strobe is accepted
			if (state == wb_bus_pkg::ST_IDLE)
				r_slave <= dec_slave;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// request routing
	////////////////////////////////////////////////////////////////////////////

	// decode steers the first cycle, the held index the wait cycle
	always_comb
	begin
		case (state)
			wb_bus_pkg::ST_IDLE: target = dec_slave;
			wb_bus_pkg::ST_WAIT: target = r_slave;
			default:             target = wb_bus_pkg::SLV_NONE;
		endcase
	end

	// request fields broadcast, stb only to the target
	assign s_ram0.cyc   = m.cyc;
	assign s_ram0.stb   = m.stb && (target == wb_bus_pkg::SLV_RAM0);
	assign s_ram0.we    = m.we;
	assign s_ram0.adr   = m.adr;
	assign s_ram0.dat_w = m.dat_w;
	assign s_ram0.sel   = m.sel;

	assign s_regs.cyc   = m.cyc;
	assign s_regs.stb   = m.stb && (target == wb_bus_pkg::SLV_REGS);
	assign s_regs.we    = m.we;
	assign s_regs.adr   = m.adr;
	assign s_regs.dat_w = m.dat_w;
	assign s_regs.sel   = m.sel;

	assign s_ram1.cyc   = m.cyc;
	assign s_ram1.stb   = m.stb && (target == wb_bus_pkg::SLV_RAM1);
	assign s_ram1.we    = m.we;
	assign s_ram1.adr   = m.adr;
	assign s_ram1.dat_w = m.dat_w;
	assign s_ram1.sel   = m.sel;

	////////////////////////////////////////////////////////////////////////////
	// response mux
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		sel_ack = 1'b0;
		sel_err = 1'b0;
		sel_dat = '0;
		case (r_slave)
			wb_bus_pkg::SLV_RAM0:
			begin
				sel_ack = s_ram0.ack;
				sel_err = s_ram0.err;
				sel_dat = s_ram0.dat_r;
			end
			wb_bus_pkg::SLV_REGS:
			begin
				sel_ack = s_regs.ack;
				sel_err = s_regs.err;
				sel_dat = s_regs.dat_r;
			end
			wb_bus_pkg::SLV_RAM1:
			begin
				sel_ack = s_ram1.ack;
				sel_err = s_ram1.err;
				sel_dat = s_ram1.dat_r;
			end
			default:
			begin
				sel_ack = 1'b0;
			end
		endcase
	end

	assign m.ack = (state == wb_bus_pkg::ST_WAIT) && sel_ack;

	// decode error is answered here, one cycle after the strobe
	assign m.err = ((state == wb_bus_pkg::ST_ERR) && m.cyc && m.stb)
		|| ((state == wb_bus_pkg::ST_WAIT) && sel_err);

	// data is zero outside the ack cycle
	assign m.dat_r = m.ack ? sel_dat : '0;

endmodule

//--- wb_sram.sv
`timescale 1ns/1ps
`include "wb_bus_config.svh"

module wb_sram
(
	input  logic  i_clk,
	input  logic  i_reset,
	wb_if.slave   s
);

	// word index width, address bits 1:0 select the byte lane
	localparam int IDX_W = $clog2(`WB_RAM_WORDS);

	wb_bus_pkg::data_t  mem [`WB_RAM_WORDS];
	wb_bus_pkg::data_t  rdata;
	logic [IDX_W-1:0]   idx;
	logic               ack;
	logic               accept;

	assign idx = s.adr[IDX_W+1:2];

	// a strobe is taken once; the held stb during ack is ignored
	assign accept = s.cyc && s.stb && !ack;

	// ack one cycle after the strobe
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			ack <= 1'b0;
		else
			ack <= accept;
	end

	////////////////////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (accept && s.we)
		begin
			// merge only the enabled byte lanes
			for (int b = 0; b < `WB_SW; b++)
			begin
				if (s.sel[b])
					mem[idx][b*8 +: 8] <= s.dat_w[b*8 +: 8];
			end
		end
		// read word lands in the ack cycle
		if (accept)
			rdata <= mem[idx];
	end

	assign s.ack = ack;
	assign s.err = 1'b0;
	assign s.dat_r = ack ? rdata : '0;

endmodule

//--- wb_regfile.sv
`timescale 1ns/1ps
`include "wb_bus_config.svh"

module wb_regfile
(
	input  logic  i_clk,
	input  logic  i_reset,
	wb_if.slave   s
);

	// register index width, taken from word address bits
	localparam int RIDX_W = $clog2(`WB_REG_COUNT);

	// every register past ID and before COUNT is scratch
	localparam int NSCRATCH = `WB_REG_COUNT - 2;

	wb_bus_pkg::reg_addr_e  raddr;
	wb_bus_pkg::data_t      scratch [NSCRATCH];
	wb_bus_pkg::data_t      count;
	wb_bus_pkg::data_t      rdata;
	logic                   ack;
	logic                   accept;

	assign raddr = wb_bus_pkg::reg_addr_e'(s.adr[RIDX_W+1:2]);
	assign accept = s.cyc && s.stb && !ack;

	////////////////////////////////////////////////////////////////////////////
	// handshake and registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			ack <= 1'b0;
			count <= '0;
			for (int r = 0; r < NSCRATCH; r++)
				scratch[r] <= '0;
		end
		else
		begin
			ack <= accept;
			// bumped at the accept edge, a COUNT read sees the old value
			if (accept)
				count <= count + 1'b1;
			// ID and COUNT drop writes silently
			if (accept && s.we)
			begin
				for (int b = 0; b < `WB_SW; b++)
				begin
					if (s.sel[b] && (raddr == wb_bus_pkg::REG_SCRATCH0))
						scratch[0][b*8 +: 8] <= s.dat_w[b*8 +: 8];
					if (s.sel[b] && (raddr == wb_bus_pkg::REG_SCRATCH1))
						scratch[1][b*8 +: 8] <= s.dat_w[b*8 +: 8];
				end
			end
		end
	end

	// read word captured alongside the ack
	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			case (raddr)
				wb_bus_pkg::REG_ID:       rdata <= `WB_ID_VALUE;
				wb_bus_pkg::REG_SCRATCH0: rdata <= scratch[0];
				wb_bus_pkg::REG_SCRATCH1: rdata <= scratch[1];
				default:                  rdata <= count;
			endcase
		end
	end

	assign s.ack = ack;
	assign s.err = 1'b0;
	assign s.dat_r = ack ? rdata : '0;

endmodule

//--- wb_subsystem_top.sv
`timescale 1ns/1ps

module wb_subsystem_top
(
	input  logic               i_clk,
	input  logic               i_reset,

	// single Wishbone classic master
	input  logic               i_wb_cyc,
	input  logic               i_wb_stb,
	input  logic               i_wb_we,
	input  wb_bus_pkg::addr_t  i_wb_adr,
	input  wb_bus_pkg::data_t  i_wb_dat,
	input  wb_bus_pkg::sel_t   i_wb_sel,
	output logic               o_wb_ack,
	output logic               o_wb_err,
	output wb_bus_pkg::data_t  o_wb_dat
);

	////////////////////////////////////////////////////////////////////////////
	// bus instances
	////////////////////////////////////////////////////////////////////////////

	// master side plus one bus per populated window
	wb_if m_bus ();
	wb_if ram0_bus ();
	wb_if regs_bus ();
	wb_if ram1_bus ();

	// plain ports onto the master bus
	assign m_bus.cyc   = i_wb_cyc;
	assign m_bus.stb   = i_wb_stb;
	assign m_bus.we    = i_wb_we;
	assign m_bus.adr   = i_wb_adr;
	assign m_bus.dat_w = i_wb_dat;
	assign m_bus.sel   = i_wb_sel;

	assign o_wb_ack = m_bus.ack;
	assign o_wb_err = m_bus.err;
	assign o_wb_dat = m_bus.dat_r;

	////////////////////////////////////////////////////////////////////////////
	// interconnect and slaves
	////////////////////////////////////////////////////////////////////////////

	wb_splitter u_wb_splitter
	(
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.m       (m_bus.slave),
		.s_ram0  (ram0_bus.master),
		.s_regs  (regs_bus.master),
		.s_ram1  (ram1_bus.master)
	);

	// window 0
	wb_sram u_wb_sram0
	(
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.s       (ram0_bus.slave)
	);

	// window 1
	wb_regfile u_wb_regfile
	(
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.s       (regs_bus.slave)
	);

	// window 2
	wb_sram u_wb_sram1
	(
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.s       (ram1_bus.slave)
	);

endmodule

//--- tb_wb_subsystem.sv
`timescale 1ns/1ps
`include "wb_bus_config.svh"

module tb_wb_subsystem;

	// about 300 transfers of two to three cycles each, doubled with room to spare
	localparam int TIMEOUT_CYCLES = 4000;
	localparam logic [`WB_NS-1:0] ALLOWED = `WB_ACCESS_ALLOWED;

	logic               i_clk;
	logic               i_reset;
	logic               i_wb_cyc;
	logic               i_wb_stb;
	logic               i_wb_we;
	wb_bus_pkg::addr_t  i_wb_adr;
	wb_bus_pkg::data_t  i_wb_dat;
	wb_bus_pkg::sel_t   i_wb_sel;
	logic               o_wb_ack;
	logic               o_wb_err;
	wb_bus_pkg::data_t  o_wb_dat;

	// reference model of both SRAMs, the scratch words and the access counter
	wb_bus_pkg::data_t  shadow_ram [2][`WB_RAM_WORDS];
	wb_bus_pkg::data_t  shadow_scratch [2];
	int                 reg_accesses = 0;
	wb_bus_pkg::addr_t  ram_addrs [$];

	// last response seen by the transfer task
	logic               rsp_ack;
	logic               rsp_err;
	wb_bus_pkg::data_t  rsp_dat;
	int                 rsp_lat;

	string              test_name = "reset";
	int                 errors = 0;
	int                 errors_at_start = 0;
	int                 passed_tests = 0;
	int                 failed_tests = 0;
	int                 cycles = 0;

	wb_subsystem_top i_wb_subsystem_top
	(
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_wb_cyc (i_wb_cyc),
		.i_wb_stb (i_wb_stb),
		.i_wb_we  (i_wb_we),
		.i_wb_adr (i_wb_adr),
		.i_wb_dat (i_wb_dat),
		.i_wb_sel (i_wb_sel),
		.o_wb_ack (o_wb_ack),
		.o_wb_err (o_wb_err),
		.o_wb_dat (o_wb_dat)
	);

	initial
	begin
		i_clk = 1'b0;
		forever
			#10 i_clk = ~i_clk;
	end

	// hang guard
	always @(posedge i_clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, the bus hung in test %s", cycles, test_name);
			$display("Simulation FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// bus protocol checks
	////////////////////////////////////////////////////////////////////////////

	a_one_response: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_wb_ack && o_wb_err))
	else
	begin
		$display("ack and err were high together in test %s", test_name);
		errors++;
	end

	a_needs_stb: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_wb_ack || o_wb_err) |-> (i_wb_cyc && i_wb_stb))
	else
	begin
		$display("a response appeared without cyc and stb in test %s", test_name);
		errors++;
	end

	// a fresh strobe gets its answer at the very next edge
	a_latency: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_wb_cyc && i_wb_stb && !o_wb_ack && !o_wb_err) |=> (o_wb_ack || o_wb_err))
	else
	begin
		$display("no response one cycle after the strobe in test %s", test_name);
		errors++;
	end

	a_dat_zero: assert property (@(posedge i_clk) disable iff (i_reset)
		!o_wb_ack |-> (o_wb_dat == '0))
	else
	begin
		$display("read data was not zero outside the ack cycle in test %s", test_name);
		errors++;
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string what, input wb_bus_pkg::data_t exp,
		input wb_bus_pkg::data_t act);
		assert (act === exp)
		else
		begin
			$display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	function automatic wb_bus_pkg::data_t merge_bytes(input wb_bus_pkg::data_t old_word,
		input wb_bus_pkg::data_t new_word, input wb_bus_pkg::sel_t sel);
		wb_bus_pkg::data_t result;
		result = old_word;
		for (int b = 0; b < `WB_SW; b++)
		begin
			if (sel[b])
				result[b*8 +: 8] = new_word[b*8 +: 8];
		end
		return result;
	endfunction

	// called on a falling edge, returns on the falling edge after the ack edge
	task automatic transfer(input logic we, input wb_bus_pkg::addr_t adr,
		input wb_bus_pkg::data_t dat, input wb_bus_pkg::sel_t sel);
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we = we;
		i_wb_adr = adr;
		i_wb_dat = dat;
		i_wb_sel = sel;
		rsp_lat = 0;
		do
		begin
			@(negedge i_clk);
			rsp_lat++;
		end
		while (!o_wb_ack && !o_wb_err);
		rsp_ack = o_wb_ack;
		rsp_err = o_wb_err;
		rsp_dat = o_wb_dat;
		// request stays up through the edge where the master takes the ack
		@(negedge i_clk);
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
	endtask

	// one transfer checked against the model, then the model is updated
	task automatic access(input logic we, input wb_bus_pkg::addr_t adr,
		input wb_bus_pkg::data_t dat, input wb_bus_pkg::sel_t sel);
		wb_bus_pkg::data_t exp_dat;
		logic exp_err;
		int win;
		int idx;
		int rix;
		// top nibble picks the window, word bits pick the offset
		win = int'(adr[31:28]);
		idx = int'(adr[9:2]);
		rix = int'(adr[3:2]);
		exp_err = (win >= `WB_NS) || !ALLOWED[win];
		exp_dat = '0;
		if (win == 0)
			exp_dat = shadow_ram[0][idx];
		else if (win == 2)
			exp_dat = shadow_ram[1][idx];
		else if (win == 1)
			exp_dat = (rix == 0) ? `WB_ID_VALUE : (rix == 3) ? reg_accesses : shadow_scratch[rix-1];
		transfer(we, adr, dat, sel);
		check_value("response {err,ack}", exp_err ? 2'b10 : 2'b01, {rsp_err, rsp_ack});
		check_value("latency", 1, rsp_lat);
		if (exp_err)
			check_value("error data", '0, rsp_dat);
		else if (!we)
			check_value($sformatf("read %h", adr), exp_dat, rsp_dat);
		if (win == 1)
			reg_accesses++;
		if (we && !exp_err)
		begin
			if (win == 0)
				shadow_ram[0][idx] = merge_bytes(shadow_ram[0][idx], dat, sel);
			else if (win == 2)
				shadow_ram[1][idx] = merge_bytes(shadow_ram[1][idx], dat, sel);
			else if (rix == 1 || rix == 2)
				shadow_scratch[rix-1] = merge_bytes(shadow_scratch[rix-1], dat, sel);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		if (errors == errors_at_start)
		begin
			passed_tests++;
			$display("test %-12s passed", test_name);
		end
		else
		begin
			failed_tests++;
			$display("test %-12s failed with %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		wb_bus_pkg::addr_t adr;
		void'($urandom(32'h45ce));
		i_reset = 1'b1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		i_wb_sel = '0;
		shadow_scratch[0] = '0;
		shadow_scratch[1] = '0;
		repeat (10) @(negedge i_clk);
		i_reset = 1'b0;
		@(negedge i_clk);

		start_test("reset_idle");
		check_value("ack and err after reset", 2'b00, {o_wb_err, o_wb_ack});
		end_test();

		// random full-word writes over both RAM windows, then read back
		start_test("sram_trip");
		for (int n = 0; n < 64; n++)
		begin
			adr = {($urandom_range(1) ? 4'h2 : 4'h0), 18'h0, 8'($urandom_range(255)), 2'b00};
			ram_addrs.push_back(adr);
			access(1'b1, adr, $urandom, 4'hF);
		end
		foreach (ram_addrs[n])
			access(1'b0, ram_addrs[n], '0, 4'hF);
		// same offset in both RAMs keeps its own value
		access(1'b1, 32'h0000_0040, 32'hA5A5_0001, 4'hF);
		access(1'b1, 32'h2000_0040, 32'h5A5A_0002, 4'hF);
		access(1'b0, 32'h0000_0040, '0, 4'hF);
		access(1'b0, 32'h2000_0040, '0, 4'hF);
		end_test();

		start_test("byte_select");
		access(1'b1, 32'h2000_0014, 32'h1122_3344, 4'hF);
		for (int s = 1; s < 15; s++)
		begin
			access(1'b1, 32'h2000_0014, $urandom, 4'(s));
			access(1'b0, 32'h2000_0014, '0, 4'hF);
			access(1'b1, 32'h1000_0008, $urandom, 4'(s));
			access(1'b0, 32'h1000_0008, '0, 4'hF);
		end
		end_test();

		// ID ignores writes, COUNT tracks every prior register access
		start_test("reg_block");
		access(1'b0, 32'h1000_0000, '0, 4'hF);
		access(1'b1, 32'h1000_0000, $urandom, 4'hF);
		access(1'b0, 32'h1000_0000, '0, 4'hF);
		access(1'b0, 32'h1000_000C, '0, 4'hF);
		access(1'b1, 32'h1000_0004, $urandom, 4'hF);
		access(1'b1, 32'h1000_000C, $urandom, 4'hF);
		access(1'b0, 32'h1000_000C, '0, 4'hF);
		access(1'b0, 32'h1000_0004, '0, 4'hF);
		end_test();

		start_test("decode_err");
		for (int n = 0; n < 8; n++)
		begin
			adr = 32'h3000_0000 | ($urandom & 32'h0FFF_FFFC);
			access(n[0], adr, $urandom, 4'hF);
			adr = $urandom_range(32'hFFFF_FFFF, 32'h4000_0000);
			access(n[0], adr, $urandom, 4'hF);
		end
		// nothing behind the refused windows moved
		foreach (ram_addrs[n])
			access(1'b0, ram_addrs[n], '0, 4'hF);
		access(1'b0, 32'h1000_0004, '0, 4'hF);
		access(1'b0, 32'h1000_0008, '0, 4'hF);
		end_test();

		// slave switching back to back, then with idle gaps
		start_test("latency");
		access(1'b0, 32'h0000_0040, '0, 4'hF);
		access(1'b0, 32'h1000_000C, '0, 4'hF);
		access(1'b1, 32'h3000_0000, $urandom, 4'hF);
		access(1'b0, 32'h2000_0040, '0, 4'hF);
		repeat (3) @(negedge i_clk);
		access(1'b1, 32'h0000_0044, $urandom, 4'h3);
		repeat (2) @(negedge i_clk);
		access(1'b0, 32'h0000_0044, '0, 4'hF);
		end_test();

		$display("tests passed %0d, tests failed %0d, check errors %0d",
			passed_tests, failed_tests, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- sources.f
+incdir+.
wb_bus_pkg.sv
wb_if.sv
addr_decode.sv
wb_splitter.sv
wb_sram.sv
wb_regfile.sv
wb_subsystem_top.sv
tb_wb_subsystem.sv

//--- Bender.yml
package:
  name: wb_subsystem

export_include_dirs:
  - .

sources:
  - wb_bus_pkg.sv
  - wb_if.sv
  - addr_decode.sv
  - wb_splitter.sv
  - wb_sram.sv
  - wb_regfile.sv
  - wb_subsystem_top.sv
  - target: test
    files:
      - tb_wb_subsystem.sv
